//--- adc_quantizer.sv
`timescale 1ns/100ps
`default_nettype none

module adc_quantizer (
    input  wire                        emu_clk,
    input  wire                        rstb,
    input  adc_slice_pkg::pwl_code_t   vin_p,
    input  adc_slice_pkg::pwl_code_t   vin_n,
    input  adc_slice_pkg::pwl_code_t   vcal,
    output logic                       q_sign,
    output adc_slice_pkg::adc_mag_t    q_mag
);

    //////////////////////////////////////////////////
    // differential input minus offset
    //////////////////////////////////////////////////

    adc_slice_pkg::diff_code_t vin_p_w;
    adc_slice_pkg::diff_code_t vin_n_w;
    adc_slice_pkg::diff_code_t vcal_w;
    adc_slice_pkg::diff_code_t diff;

    // sign extend before subtracting, no overflow at 18 bits
    assign vin_p_w = adc_slice_pkg::diff_code_t'(vin_p);
    assign vin_n_w = adc_slice_pkg::diff_code_t'(vin_n);
    assign vcal_w  = adc_slice_pkg::diff_code_t'(vcal);

    assign diff = vin_p_w - vin_n_w - vcal_w;

    //////////////////////////////////////////////////
    // sign and magnitude
    //////////////////////////////////////////////////

    logic                               diff_neg;
    logic [adc_slice_pkg::DIFF_W-1:0]   diff_abs;
    logic [adc_slice_pkg::DIFF_W-1:0]   diff_scaled;
    adc_slice_pkg::adc_mag_t            mag_sat;

    assign diff_neg = diff[adc_slice_pkg::DIFF_W-1];

    // most negative code cannot occur here, so negation is safe
    assign diff_abs = diff_neg ? -diff : diff;

    // drop lsbs, this sets the quantizer step
    assign diff_scaled = diff_abs >> adc_slice_pkg::ADC_SHIFT;

    // clip to full scale of the magnitude output
    always_comb begin
        if (diff_scaled > adc_slice_pkg::ADC_MAX) begin
            mag_sat = adc_slice_pkg::ADC_MAX;
        end else begin
            mag_sat = diff_scaled[adc_slice_pkg::NADC-1:0];
        end
    end

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////

    // one cycle latency, updated every emu_clk
    always_ff @(posedge emu_clk or negedge rstb) begin
        if (!rstb) begin
            q_sign <= 1'b0;
            q_mag  <= '0;
        end else begin
            q_sign <= diff_neg;
            q_mag  <= mag_sat;
        end
    end

endmodule

`default_nettype wire

//--- adc_slice_pkg.sv
`default_nettype none

package adc_slice_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    // analog input and calibration codes
    localparam int PWL_W = 16;
    // difference of three codes needs two extra bits
    localparam int DIFF_W = 18;
    localparam int NADC = 8;
    localparam int NDIV = 2;

    //////////////////////////////////////////////////
    // code types
    //////////////////////////////////////////////////

    typedef logic signed [PWL_W-1:0] pwl_code_t;
    typedef logic signed [DIFF_W-1:0] diff_code_t;
    typedef logic [NADC-1:0] adc_mag_t;
    typedef logic [NDIV-1:0] div_count_t;

    // quantizer scaling, low bits dropped from |diff|
    localparam int ADC_SHIFT = 6;
    // magnitude clips here
    localparam adc_mag_t ADC_MAX = 8'd255;

    // counter value under the always-on override
    localparam div_count_t DIV_FULL = '1;

    // divider control state
    typedef enum logic [1:0] {
        DIV_HOLD,
        DIV_RUN,
        DIV_FORCED
    } div_mode_t;

endpackage

`default_nettype wire

//--- adc_slice_props.sv
`timescale 1ns/100ps
`default_nettype none

module adc_slice_props (
    input wire                      emu_clk,
    input wire                      rstb,
    input wire                      clk_in,
    input wire                      en_sync,
    input wire                      clk_adder,
    input wire                      en_sync_out,
    input adc_slice_pkg::adc_mag_t  adder_out
);

    // en_sync_out moves one posedge after a sampled clk_in rise
    assert property (@(posedge emu_clk) disable iff (!rstb)
        $changed(en_sync_out) |-> ($past(clk_in) && !$past(clk_in, 2)))
        else $error("en_sync_out changed without a clk_in rise");

    // counter moves on a clk_in fall, or loads init while disabled
    assert property (@(posedge emu_clk) disable iff (!rstb)
        $changed(clk_adder) |->
            ((!$past(clk_in) && $past(clk_in, 2)) || !$past(en_sync)))
        else $error("clk_adder changed without a clk_in fall");

    // output capture only right after the adder clock rise
    assert property (@(posedge emu_clk) disable iff (!rstb)
        $changed(adder_out) |-> ($past(clk_adder) && !$past(clk_adder, 2)))
        else $error("adder_out changed outside a clk_adder rise");

endmodule

bind adc_slice_top adc_slice_props u_props (
    .emu_clk     (emu_clk),
    .rstb        (rstb),
    .clk_in      (clk_in),
    .en_sync     (u_clock_ctrl.en_sync),
    .clk_adder   (clk_adder),
    .en_sync_out (en_sync_out),
    .adder_out   (adder_out)
);

`default_nettype wire

//--- adc_slice_tb.sv
`timescale 1ns/100ps
`default_nettype none

module adc_slice_tb;

    // clk_in periods used by all tests, 8 emu_clk cycles each
    localparam int TEST_PERIODS = 4 + 12 + 6 + 48 + 7;
    // reset and the cycles around its release come first
    localparam int TOTAL_CYCLES = 10 + 8 * TEST_PERIODS;
    localparam int WATCHDOG_NS = TOTAL_CYCLES * 10 * 3 / 2;

    wire                         emu_clk;
    wire                         rstb;
    logic                        clk_in;
    logic                        en_slice;
    logic                        en_sync_in;
    logic                        alws_on;
    adc_slice_pkg::div_count_t   init;
    adc_slice_pkg::pwl_code_t    vin_p;
    adc_slice_pkg::pwl_code_t    vin_n;
    adc_slice_pkg::pwl_code_t    vcal;
    wire                         clk_adder;
    wire                         en_sync_out;
    wire                         sign_out;
    adc_slice_pkg::adc_mag_t     adder_out;

    logic [31:0] rng_state;

    tb_clock_gen u_clock_gen (
        .emu_clk (emu_clk),
        .rstb    (rstb)
    );

    adc_slice_top DUT (
        .emu_clk     (emu_clk),
        .rstb        (rstb),
        .clk_in      (clk_in),
        .en_slice    (en_slice),
        .en_sync_in  (en_sync_in),
        .alws_on     (alws_on),
        .init        (init),
        .vin_p       (vin_p),
        .vin_n       (vin_n),
        .vcal        (vcal),
        .clk_adder   (clk_adder),
        .en_sync_out (en_sync_out),
        .sign_out    (sign_out),
        .adder_out   (adder_out)
    );

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // {sign, magnitude} of (p - n - c), scaled by 64, clipped at 255
    function automatic logic [8:0] quantize(input logic signed [15:0] p,
                                            input logic signed [15:0] n,
                                            input logic signed [15:0] c);
        int d;
        int a;
        d = int'(p) - int'(n) - int'(c);
        a = (d < 0) ? -d : d;
        a = a / 64;
        if (a > 255) begin
            a = 255;
        end
        return {d < 0, a[7:0]};
    endfunction

    logic       m_clk_prev;
    logic       m_sampled;
    logic       m_sync_out;
    logic [1:0] m_count;
    logic       m_adder_prev;
    logic [8:0] m_q;
    logic [8:0] m_out;

    always @(posedge emu_clk or negedge rstb) begin
        logic       fall;
        logic       rise;
        logic       en_sync;
        logic       adder_now;
        logic [1:0] next_count;
        if (!rstb) begin
            m_clk_prev   = 1'b0;
            m_sampled    = 1'b0;
            m_sync_out   = 1'b0;
            m_count      = 2'b00;
            m_adder_prev = 1'b0;
            m_q          = '0;
            m_out        = '0;
        end else begin
            fall = m_clk_prev & ~clk_in;
            rise = ~m_clk_prev & clk_in;
            en_sync = m_sampled & en_slice;
            if (!en_sync) begin
                next_count = init;
            end else if (alws_on) begin
                next_count = 2'b11;
            end else if (fall) begin
                next_count = m_count + 2'd1;
            end else begin
                next_count = m_count;
            end
            adder_now = ~m_count[1];
            if (adder_now && !m_adder_prev) begin
                m_out = m_q;
            end
            m_adder_prev = adder_now;
            m_q = quantize(vin_p, vin_n, vcal);
            if (rise) begin
                m_sync_out = m_sampled;
            end
            if (fall) begin
                m_sampled = en_sync_in;
            end
            m_count = next_count;
            m_clk_prev = clk_in;
        end
    end

    //////////////////////////////////////////////////
    // checking and stepping
    //////////////////////////////////////////////////

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s is %0h, expected %0h",
                     $time, name, actual, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic compare_model();
        check("en_sync_out", en_sync_out, m_sync_out);
        check("clk_adder", clk_adder, !m_count[1]);
        check("sign_out", sign_out, m_out[8]);
        check("adder_out", adder_out, m_out[7:0]);
    endtask

    // one half period of clk_in, driven on the falling emu_clk edge
    task automatic clk_in_half(input logic level);
        @(negedge emu_clk);
        clk_in = level;
        compare_model();
        repeat (3) begin
            @(negedge emu_clk);
            compare_model();
        end
    endtask

    task automatic clk_in_periods(input int n);
        repeat (n) begin
            clk_in_half(1'b1);
            clk_in_half(1'b0);
        end
    endtask

    task automatic randomize_inputs();
        rng_state = xorshift(rng_state);
        vin_p = rng_state[15:0];
        vin_n = rng_state[31:16];
        rng_state = xorshift(rng_state);
        vcal = {{6{rng_state[9]}}, rng_state[9:0]};
    endtask

    // new codes every cycle with clk_in parked, outputs keep the last capture
    task automatic vary_inputs_expect_hold(input logic [8:0] held);
        repeat (8) begin
            @(negedge emu_clk);
            randomize_inputs();
            compare_model();
            check("sign_out", sign_out, held[8]);
            check("adder_out", adder_out, held[7:0]);
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic test_reset_values();
        check("en_sync_out", en_sync_out, 0);
        check("sign_out", sign_out, 0);
        check("adder_out", adder_out, 0);
        check("clk_adder", clk_adder, 1);
    endtask

    task automatic test_enable_sync();
        en_sync_in = 1'b1;
        clk_in_half(1'b1);
        clk_in_half(1'b0);
        // fall seen, rise still to come
        check("en_sync_out", en_sync_out, 0);
        clk_in_half(1'b1);
        check("en_sync_out", en_sync_out, 1);
        clk_in_half(1'b0);
        en_sync_in = 1'b0;
        clk_in_periods(1);
        check("en_sync_out", en_sync_out, 1);
        clk_in_periods(1);
        check("en_sync_out", en_sync_out, 0);
    endtask

    task automatic test_divider();
        en_sync_in = 1'b1;
        en_slice = 1'b0;
        for (int i = 0; i < 4; i++) begin
            init = i[1:0];
            clk_in_periods(1);
            check("clk_adder", clk_adder, !init[1]);
        end
        init = 2'b00;
        en_slice = 1'b1;
        clk_in_periods(8);
    endtask

    task automatic test_always_on();
        alws_on = 1'b1;
        clk_in_periods(2);
        check("clk_adder", clk_adder, 0);
        alws_on = 1'b0;
        clk_in_periods(4);
    endtask

    task automatic test_conversion();
        logic [8:0] expected;
        for (int i = 0; i < 12; i++) begin
            case (i)
                0: begin
                    vin_p = 16'sd16320;
                    vin_n = 16'sd0;
                    vcal = 16'sd0;
                end
                1: begin
                    vin_p = 16'sd0;
                    vin_n = 16'sd16319;
                    vcal = 16'sd0;
                end
                2: begin
                    vin_p = 16'h7fff;
                    vin_n = 16'h8000;
                    vcal = -16'sd5;
                end
                3: begin
                    vin_p = 16'h8000;
                    vin_n = 16'h7fff;
                    vcal = 16'sd7;
                end
                default: randomize_inputs();
            endcase
            // four falls give one full adder clock period
            clk_in_periods(4);
            expected = quantize(vin_p, vin_n, vcal);
            check("sign_out", sign_out, expected[8]);
            check("adder_out", adder_out, expected[7:0]);
        end
    endtask

    task automatic test_hold();
        logic [8:0] expected;
        randomize_inputs();
        expected = quantize(vin_p, vin_n, vcal);
        clk_in_periods(4);
        check("sign_out", sign_out, expected[8]);
        check("adder_out", adder_out, expected[7:0]);
        // clk_adder stays low here
        vary_inputs_expect_hold(expected);
        // next fall raises clk_adder, only the last codes get through
        expected = quantize(vin_p, vin_n, vcal);
        clk_in_periods(1);
        check("sign_out", sign_out, expected[8]);
        check("adder_out", adder_out, expected[7:0]);
        // clk_adder stays high here
        vary_inputs_expect_hold(expected);
    endtask

    //////////////////////////////////////////////////
    // run control
    //////////////////////////////////////////////////

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the tests did not finish in time");
        $display("Errors found");
        $fatal(1);
    end

    initial begin
        rng_state = 32'hbd73;
        clk_in = 1'b0;
        en_slice = 1'b0;
        en_sync_in = 1'b0;
        alws_on = 1'b0;
        init = 2'b00;
        vin_p = '0;
        vin_n = '0;
        vcal = '0;
        @(posedge rstb);
        @(negedge emu_clk);
        test_reset_values();
        test_enable_sync();
        test_divider();
        test_always_on();
        test_conversion();
        test_hold();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- adc_slice_top.sv
`timescale 1ns/100ps
`default_nettype none

module adc_slice_top (
    input  wire                        emu_clk,
    input  wire                        rstb,
    input  wire                        clk_in,
    input  wire                        en_slice,
    input  wire                        en_sync_in,
    input  wire                        alws_on,
    input  adc_slice_pkg::div_count_t  init,
    input  adc_slice_pkg::pwl_code_t   vin_p,
    input  adc_slice_pkg::pwl_code_t   vin_n,
    input  adc_slice_pkg::pwl_code_t   vcal,
    output wire                        clk_adder,
    output wire                        en_sync_out,
    output wire                        sign_out,
    output adc_slice_pkg::adc_mag_t    adder_out
);

    // quantizer result on its way to the latch
    wire                      q_sign;
    adc_slice_pkg::adc_mag_t  q_mag;

    //////////////////////////////////////////////////
    // timing path
    //////////////////////////////////////////////////

    slice_clock_ctrl u_clock_ctrl (
        .emu_clk     (emu_clk),
        .rstb        (rstb),
        .clk_in      (clk_in),
        .en_slice    (en_slice),
        .en_sync_in  (en_sync_in),
        .alws_on     (alws_on),
        .init        (init),
        .en_sync_out (en_sync_out),
        .clk_adder   (clk_adder)
    );

    //////////////////////////////////////////////////
    // conversion path
    //////////////////////////////////////////////////

    adc_quantizer u_quantizer (
        .emu_clk (emu_clk),
        .rstb    (rstb),
        .vin_p   (vin_p),
        .vin_n   (vin_n),
        .vcal    (vcal),
        .q_sign  (q_sign),
        .q_mag   (q_mag)
    );

    // adder clock rise lets the conversion result out
    slice_output_latch u_output_latch (
        .emu_clk   (emu_clk),
        .rstb      (rstb),
        .clk_adder (clk_adder),
        .q_sign    (q_sign),
        .q_mag     (q_mag),
        .sign_out  (sign_out),
        .adder_out (adder_out)
    );

endmodule

`default_nettype wire

//--- compile.f
adc_slice_pkg.sv
slice_clock_ctrl.sv
adc_quantizer.sv
slice_output_latch.sv
adc_slice_top.sv
tb_clock_gen.sv
adc_slice_props.sv
adc_slice_tb.sv

//--- slice_clock_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module slice_clock_ctrl (
    input  wire                        emu_clk,
    input  wire                        rstb,
    input  wire                        clk_in,
    input  wire                        en_slice,
    input  wire                        en_sync_in,
    input  wire                        alws_on,
    input  adc_slice_pkg::div_count_t  init,
    output logic                       en_sync_out,
    output logic                       clk_adder
);

    //////////////////////////////////////////////////
    // clk_in edge detection
    //////////////////////////////////////////////////

    // clk_in is slow, so emu_clk samples it like data
    logic clk_in_prev;
    logic negedge_clk_in;
    logic posedge_clk_in;

    always_ff @(posedge emu_clk or negedge rstb) begin
        if (!rstb) begin
            clk_in_prev <= 1'b0;
        end else begin
            clk_in_prev <= clk_in;
        end
    end

    // strobes last one emu_clk cycle per slice clock edge
    assign negedge_clk_in = clk_in_prev & ~clk_in;
    assign posedge_clk_in = ~clk_in_prev & clk_in;

    //////////////////////////////////////////////////
    // enable synchronization
    //////////////////////////////////////////////////

    logic en_sync_in_sampled;
    logic en_sync;

    // sample on the falling slice clock edge
    always_ff @(posedge emu_clk or negedge rstb) begin
        if (!rstb) begin
            en_sync_in_sampled <= 1'b0;
        end else if (negedge_clk_in) begin
            en_sync_in_sampled <= en_sync_in;
        end
    end

    // pass on to the next slice at the rising edge
    always_ff @(posedge emu_clk or negedge rstb) begin
        if (!rstb) begin
            en_sync_out <= 1'b0;
        end else if (posedge_clk_in) begin
            en_sync_out <= en_sync_in_sampled;
        end
    end

    assign en_sync = en_sync_in_sampled & en_slice;

    //////////////////////////////////////////////////
    // divider
    //////////////////////////////////////////////////

    adc_slice_pkg::div_mode_t  div_mode;
    adc_slice_pkg::div_count_t count;

    // en_sync has priority over the override
    always_comb begin
        if (!en_sync) begin
            div_mode = adc_slice_pkg::DIV_HOLD;
        end else if (alws_on) begin
            div_mode = adc_slice_pkg::DIV_FORCED;
        end else begin
            div_mode = adc_slice_pkg::DIV_RUN;
        end
    end

    always_ff @(posedge emu_clk or negedge rstb) begin
        if (!rstb) begin
            count <= '0;
        end else begin
            case (div_mode)
                adc_slice_pkg::DIV_HOLD: begin
                    // preload sets the phase of this slice
                    count <= init;
                end
                adc_slice_pkg::DIV_FORCED: begin
                    count <= adc_slice_pkg::DIV_FULL;
                end
                adc_slice_pkg::DIV_RUN: begin
                    if (negedge_clk_in) begin
                        count <= count + 1'b1;
                    end
                end
                default: begin
                    count <= init;
                end
            endcase
        end
    end

    // adder clock from the counter msb, inverted
    // high right after reset since count clears to zero
    assign clk_adder = ~count[adc_slice_pkg::NDIV-1];

endmodule

`default_nettype wire

//--- slice_output_latch.sv
`timescale 1ns/100ps
`default_nettype none

module slice_output_latch (
    input  wire                        emu_clk,
    input  wire                        rstb,
    input  wire                        clk_adder,
    input  wire                        q_sign,
    input  adc_slice_pkg::adc_mag_t    q_mag,
    output logic                       sign_out,
    output adc_slice_pkg::adc_mag_t    adder_out
);

    //////////////////////////////////////////////////
    // clk_adder edge detection
    //////////////////////////////////////////////////

    logic clk_adder_prev;
    logic capture;

    always_ff @(posedge emu_clk or negedge rstb) begin
        if (!rstb) begin
            clk_adder_prev <= 1'b0;
        end else begin
            clk_adder_prev <= clk_adder;
        end
    end

    // first cycle with the adder clock high
    assign capture = clk_adder & ~clk_adder_prev;

    //////////////////////////////////////////////////
    // slice outputs
    //////////////////////////////////////////////////

    // takes whatever the quantizer holds at the rise,
    // then keeps it until the next rise
    always_ff @(posedge emu_clk or negedge rstb) begin
        if (!rstb) begin
            sign_out  <= 1'b0;
            adder_out <= '0;
        end else if (capture) begin
            sign_out  <= q_sign;
            adder_out <= q_mag;
        end
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic emu_clk,
    output logic rstb
);

    localparam real HALF_NS = 5.0;
    localparam int  RESET_CYCLES = 8;

    initial begin
        emu_clk = 1'b0;
        forever #(HALF_NS) emu_clk = ~emu_clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rstb = 1'b0;
        repeat (RESET_CYCLES) @(posedge emu_clk);
        @(negedge emu_clk);
        rstb = 1'b1;
    end

endmodule

`default_nettype wire
